// File: Bender.yml
package:
  name: bpu

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/bpu_pkg.sv
      - design/ubtb.sv
      - design/main_btb.sv
      - design/ras_stack.sv
      - design/s2_resolve.sv
      - design/pred_frontend.sv
      - design/stream_queue.sv
      - design/bpu_top.sv
      - target: test
        files:
          - bench/tb_bpu.sv

// File: bench/tb_bpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "bpu_consts.svh"

module tb_bpu;
    import bpu_pkg::*;

    localparam int MAX_CYCLES = 2000;   // tests need roughly 400 cycles.

    logic              clk;
    logic              rst_i;
    logic              fb_valid_i;
    logic              fb_kind_i;
    fb_word_u          fb_word_i;
    logic              stream_ready_i;
    logic              stream_valid_o;
    stream_entry_t     stream_o;

    stream_entry_t     got_q [$];       // entries popped by the fetch side.
    int                checks;
    int                errors;
    int                cycle_cnt;
    logic [31:0]       rng_state = 32'h48a82350;

    // reference copy of the main btb and the return stack.
    logic              m_valid  [`BPU_BTB_SETS];
    logic [23:0]       m_tag    [`BPU_BTB_SETS];
    logic [1:0]        m_off    [`BPU_BTB_SETS];
    br_type_e          m_type   [`BPU_BTB_SETS];
    logic [31:0]       m_target [`BPU_BTB_SETS];
    logic [1:0]        m_ctr    [`BPU_BTB_SETS];
    logic [31:0]       m_ras    [`BPU_RAS_DEPTH];
    int                ras_ptr;

    bpu_top bpu_top_i (.clk, .rst_i, .fb_valid_i, .fb_kind_i, .fb_word_i, .stream_ready_i,
        .stream_valid_o, .stream_o);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ######################################################################
    // helpers.
    // ######################################################################
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_entry(input string name, input stream_entry_t exp,
                               input stream_entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected start=%h end_off=%0d taken=%b target=%h",
                     $time, name, exp.start, exp.end_off, exp.taken, exp.target);
            $display("[FAIL] %0t %s got      start=%h end_off=%0d taken=%b target=%h",
                     $time, name, act.start, act.end_off, act.taken, act.target);
        end
    endtask

    // next entry from a block start, moving the stack like stage 2 does.
    function automatic stream_entry_t predict(input logic [31:0] start);
        stream_entry_t e;
        int            idx;
        logic          taken;
        idx   = start[7:4];
        taken = m_valid[idx] && (m_tag[idx] == start[31:8])
                && ((m_type[idx] != BR_COND) || m_ctr[idx][1]);
        e.start   = start;
        e.taken   = taken;
        e.end_off = 2'd3;
        e.target  = start + 32'd16;
        if (taken) begin
            e.end_off = m_off[idx];
            e.target  = m_target[idx];
            if (m_type[idx] == BR_RET) begin
                e.target = m_ras[ras_ptr];
                ras_ptr  = (ras_ptr + `BPU_RAS_DEPTH - 1) % `BPU_RAS_DEPTH;
            end
            if (m_type[idx] == BR_CALL) begin
                ras_ptr = (ras_ptr + 1) % `BPU_RAS_DEPTH;
                m_ras[ras_ptr] = start + 32'd4 * (32'(m_off[idx]) + 32'd1);
            end
        end
        return e;
    endfunction

    task automatic collect_pops();
        forever begin
            @(negedge clk);
            // a flush cycle pops nothing.
            if (!rst_i && stream_valid_o && stream_ready_i && !(fb_valid_i && !fb_kind_i))
                got_q.push_back(stream_o);
        end
    endtask

    task automatic train_branch(input logic [31:0] block, input logic [1:0] off,
                                input br_type_e btype, input logic taken,
                                input logic [31:0] target);
        int   idx;
        logic hit;
        @(posedge clk);
        #1;
        fb_valid_i = 1'b1;
        fb_kind_i  = 1'b1;
        fb_word_i  = '0;
        fb_word_i.train.block_addr = block[31:4];
        fb_word_i.train.slot_off   = off;
        fb_word_i.train.br_type    = btype;
        fb_word_i.train.taken      = taken;
        fb_word_i.train.target     = target[31:1];
        idx = block[7:4];
        hit = m_valid[idx] && (m_tag[idx] == block[31:8]);
        if (!hit) m_ctr[idx] = 2'd2;                    // new entry, weakly taken.
        else if (btype != BR_COND) m_ctr[idx] = 2'd3;
        else if (taken && m_ctr[idx] != 2'd3) m_ctr[idx] = m_ctr[idx] + 2'd1;
        else if (!taken && m_ctr[idx] != 2'd0) m_ctr[idx] = m_ctr[idx] - 2'd1;
        m_valid[idx]  = 1'b1;
        m_tag[idx]    = block[31:8];
        m_off[idx]    = off;
        m_type[idx]   = btype;
        m_target[idx] = target;
        @(posedge clk);
        #1;
        fb_valid_i = 1'b0;
    endtask

    task automatic squash_to(input logic [31:0] pc);
        @(posedge clk);
        #1;
        fb_valid_i = 1'b1;
        fb_kind_i  = 1'b0;
        fb_word_i  = '0;
        fb_word_i.squash.target_pc = pc;
        got_q.delete();
        @(posedge clk);
        #1;
        fb_valid_i = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_bit("stream_valid_o", 1'b0, stream_valid_o);  // queue empty.
        end
    endtask

    // waits for n pops and checks them against the model chain.
    task automatic expect_run(input logic [31:0] start, input int n, input bit rand_ready);
        stream_entry_t exp_q [$];
        stream_entry_t e;
        logic [31:0]   pc;
        logic [31:0]   r;
        int            burst_left;
        logic          level;
        pc         = start;
        burst_left = 0;
        level      = 1'b1;
        for (int i = 0; i < n; i++) begin
            e = predict(pc);
            exp_q.push_back(e);
            pc = e.target;
        end
        while (got_q.size() < n) begin
            @(posedge clk);
            #1;
            if (rand_ready) begin
                if (burst_left == 0) begin
                    r          = next_rand();
                    burst_left = 1 + r[4:0];            // bursts up to 32 cycles.
                    level      = r[8];
                end
                stream_ready_i = level;
                burst_left--;
            end
        end
        stream_ready_i = 1'b1;
        for (int i = 0; i < n; i++)
            check_entry($sformatf("stream_o[%0d]", i), exp_q[i], got_q[i]);
    endtask

    // ######################################################################
    // directed tests.
    // ######################################################################
    task automatic sequential_after_reset();
        repeat (2) begin
            @(negedge clk);
            check_bit("stream_valid_o", 1'b0, stream_valid_o);
        end
        expect_run(`BPU_RESET_PC, 8, 1'b0);
    endtask

    task automatic trained_jump();
        logic [31:0] tgt;
        tgt = 32'h0001_0000 | (next_rand() & 32'h0000_fff0);
        train_branch(32'h0000_2000, 2'd1, BR_JUMP, 1'b1, tgt);
        squash_to(32'h0000_2000);
        expect_run(32'h0000_2000, 4, 1'b0);
    endtask

    task automatic cond_counter();
        train_branch(32'h0000_3040, 2'd1, BR_COND, 1'b1, 32'h0000_3800);  // counter 2.
        train_branch(32'h0000_3040, 2'd1, BR_COND, 1'b1, 32'h0000_3800);  // counter 3.
        squash_to(32'h0000_3040);
        expect_run(32'h0000_3040, 4, 1'b0);
        // counter 2, micro btb entry gone, so stage 2 overrides.
        train_branch(32'h0000_3040, 2'd1, BR_COND, 1'b0, 32'h0000_3800);
        squash_to(32'h0000_3040);
        expect_run(32'h0000_3040, 4, 1'b0);
        train_branch(32'h0000_3040, 2'd1, BR_COND, 1'b0, 32'h0000_3800);
        squash_to(32'h0000_3040);
        expect_run(32'h0000_3040, 4, 1'b0);
    endtask

    task automatic call_return();
        train_branch(32'h0000_6000, 2'd3, BR_CALL, 1'b1, 32'h0000_7a50);
        train_branch(32'h0000_7a50, 2'd0, BR_RET, 1'b1, 32'h0000_0000);
        squash_to(32'h0000_6000);
        expect_run(32'h0000_6000, 5, 1'b0);
    endtask

    task automatic ready_backpressure();
        logic [31:0] t1;
        t1 = 32'h0003_0040 | (next_rand() & 32'h0000_ff00);
        train_branch(32'h0002_0000, 2'd2, BR_JUMP, 1'b1, t1);
        train_branch(t1 + 32'd32, 2'd1, BR_JUMP, 1'b1, 32'h0002_0000);
        squash_to(32'h0002_0000);
        expect_run(32'h0002_0000, 40, 1'b1);
    endtask

    task automatic squash_midstream();
        @(posedge clk);
        #1;
        stream_ready_i = 1'b0;                  // let the queue fill up.
        repeat (12) @(posedge clk);
        squash_to(32'h0000_9000);
        expect_run(32'h0000_9000, 6, 1'b1);
    endtask

    task automatic report_and_finish();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // ######################################################################
    // run.
    // ######################################################################
    initial begin
        rst_i          = 1'b1;
        fb_valid_i     = 1'b0;
        fb_kind_i      = 1'b0;
        fb_word_i      = '0;
        stream_ready_i = 1'b1;
        checks         = 0;
        errors         = 0;
        ras_ptr        = 0;
        for (int i = 0; i < `BPU_BTB_SETS; i++) m_valid[i] = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;
        sequential_after_reset();
        trained_jump();
        cond_counter();
        call_return();
        ready_backpressure();
        squash_midstream();
        report_and_finish();
    end

    initial begin
        collect_pops();
    end

    initial begin
        for (cycle_cnt = 0; cycle_cnt < MAX_CYCLES; cycle_cnt++) @(posedge clk);
        $display("timeout, expected entries did not arrive within %0d cycles", MAX_CYCLES);
        errors++;
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/bpu_pkg.sv
design/ubtb.sv
design/main_btb.sv
design/ras_stack.sv
design/s2_resolve.sv
design/pred_frontend.sv
design/stream_queue.sv
design/bpu_top.sv
bench/tb_bpu.sv

// File: design/bpu_consts.svh
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// ##########################################################################
// branch prediction unit sizes.
// ##########################################################################

// first fetch block after reset, 16-byte aligned.
`define BPU_RESET_PC 32'h0000_1000

// stage-1 micro btb, fully associative.
`define BPU_UBTB_ENTRIES 4

// stage-2 main btb, direct mapped.
// index is address bits 7:4, tag is bits 31:8.
`define BPU_BTB_SETS 16

// return address stack depth.
`define BPU_RAS_DEPTH 4

// fetch stream queue depth.
// space drops two entries early because stage 2 may still write
// in the cycle after it falls.
`define BPU_QUEUE_DEPTH 8

// ##########################################################################
// end of sizes.
// ##########################################################################

`endif

// File: design/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // branch kinds known to the btb.
    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_JUMP = 2'd1,
        BR_CALL = 2'd2,
        BR_RET  = 2'd3
    } br_type_e;

    // squash view of a feedback word.
    typedef struct packed {
        logic [31:0] target_pc;
        logic [31:0] pad;
    } fb_squash_t;

    // training view, one branch per block.
    typedef struct packed {
        logic [27:0] block_addr;    // address bits 31:4.
        logic [1:0]  slot_off;
        br_type_e    br_type;
        logic        taken;
        logic [30:0] target;        // address bits 31:1.
    } fb_train_t;

    // the kind strobe picks which view is live.
    typedef union packed {
        fb_squash_t squash;
        fb_train_t  train;
    } fb_word_u;

    // one fetch block handed to the fetch unit.
    typedef struct packed {
        logic [31:0] start;
        logic [1:0]  end_off;       // offset of last instruction fetched.
        logic        taken;
        logic [31:0] target;        // start of the next block.
    } stream_entry_t;

endpackage

`default_nettype wire

// File: design/bpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module bpu_top (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   fb_valid_i,
    input  logic                   fb_kind_i,
    input  bpu_pkg::fb_word_u      fb_word_i,
    input  logic                   stream_ready_i,
    output logic                   stream_valid_o,
    output bpu_pkg::stream_entry_t stream_o
);
    import bpu_pkg::*;

    logic          enq, flush, space;
    stream_entry_t enq_entry;

    pred_frontend pred_frontend_i (.clk, .rst_i, .fb_valid_i, .fb_kind_i, .fb_word_i,
        .space_i(space), .enq_o(enq), .enq_entry_o(enq_entry), .flush_o(flush));

    // the fetch unit pops straight from the queue head.
    stream_queue stream_queue_i (.clk, .rst_i, .enq_i(enq), .enq_entry_i(enq_entry),
        .flush_i(flush), .space_o(space), .deq_i(stream_ready_i),
        .valid_o(stream_valid_o), .head_o(stream_o));

endmodule

`default_nettype wire

// File: design/main_btb.sv
`timescale 1ns/100ps
`default_nettype none
`include "bpu_consts.svh"

module main_btb #(
    parameter int SETS = `BPU_BTB_SETS
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic [27:0]       lookup_addr_i,
    output logic              hit_o,
    output logic [1:0]        slot_off_o,
    output bpu_pkg::br_type_e type_o,
    output logic [31:0]       target_o,
    output logic [1:0]        ctr_o,
    input  logic              train_i,
    input  bpu_pkg::fb_word_u train_word_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 28 - IDX_W;

    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_q    [SETS];
    logic [1:0]       off_q    [SETS];
    br_type_e         btype_q  [SETS];
    logic [31:0]      target_q [SETS];
    logic [1:0]       ctr_q    [SETS];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    fb_train_t        tw;
    logic             tw_hit;
    logic [1:0]       ctr_old;
    logic [1:0]       ctr_new;

    // ######################################################################
    // lookup.
    // ######################################################################
    assign rd_idx     = lookup_addr_i[IDX_W-1:0];
    assign hit_o      = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_addr_i[27:IDX_W]);
    assign slot_off_o = off_q[rd_idx];
    assign type_o     = btype_q[rd_idx];
    assign target_o   = target_q[rd_idx];
    assign ctr_o      = ctr_q[rd_idx];

    // ######################################################################
    // training.
    // ######################################################################
    assign tw      = train_word_i.train;
    assign wr_idx  = tw.block_addr[IDX_W-1:0];
    assign tw_hit  = valid_q[wr_idx] && (tag_q[wr_idx] == tw.block_addr[27:IDX_W]);
    assign ctr_old = ctr_q[wr_idx];

    always_comb begin
        if (!tw_hit)                 ctr_new = 2'd2;    // fresh entry, weakly taken.
        else if (tw.br_type != BR_COND) ctr_new = 2'd3;
        else if (tw.taken)           ctr_new = (ctr_old == 2'd3) ? 2'd3 : ctr_old + 2'd1;
        else                         ctr_new = (ctr_old == 2'd0) ? 2'd0 : ctr_old - 2'd1;
    end

    always_ff @(posedge clk) begin
        if (rst_i) valid_q <= '0;
        else if (train_i) valid_q[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (train_i) begin
            tag_q[wr_idx]    <= tw.block_addr[27:IDX_W];
            off_q[wr_idx]    <= tw.slot_off;
            btype_q[wr_idx]  <= tw.br_type;
            target_q[wr_idx] <= {tw.target, 1'b0};
            ctr_q[wr_idx]    <= ctr_new;
        end
    end

endmodule

`default_nettype wire

// File: design/pred_frontend.sv
`timescale 1ns/100ps
`default_nettype none
`include "bpu_consts.svh"

module pred_frontend (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   fb_valid_i,
    input  logic                   fb_kind_i,
    input  bpu_pkg::fb_word_u      fb_word_i,
    input  logic                   space_i,
    output logic                   enq_o,
    output bpu_pkg::stream_entry_t enq_entry_o,
    output logic                   flush_o
);
    import bpu_pkg::*;

    logic [31:0] pc_q;
    logic        s2_valid_q;
    logic [31:0] s2_block_q;
    logic [31:0] s2_s1_target_q;                // what stage 1 guessed.
    logic        squash, train, stall, override;
    logic        ub_hit;
    logic [31:0] ub_target, s1_target;
    logic        btb_hit;
    logic [1:0]  btb_off, btb_ctr;
    br_type_e    btb_type;
    logic [31:0] btb_target;
    logic        ras_push, ras_pop;
    logic [31:0] ras_push_addr, ras_top;

    assign squash    = fb_valid_i && !fb_kind_i;
    assign train     = fb_valid_i && fb_kind_i;
    assign stall     = !space_i;
    assign s1_target = ub_hit ? ub_target : pc_q + 32'd16;
    assign enq_o     = s2_valid_q && space_i && !squash;
    assign flush_o   = squash;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= `BPU_RESET_PC;
            s2_valid_q <= 1'b0;
        end else if (squash) begin
            pc_q       <= fb_word_i.squash.target_pc;
            s2_valid_q <= 1'b0;
        end else if (override) begin
            pc_q <= enq_entry_o.target;         // drop the block in the pc.
            if (!stall) s2_valid_q <= 1'b0;
        end else if (!stall) begin
            pc_q       <= s1_target;
            s2_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s2_block_q     <= pc_q;
            s2_s1_target_q <= s1_target;
        end
    end

    ubtb ubtb_i (.clk, .rst_i, .lookup_pc_i(pc_q), .hit_o(ub_hit), .target_o(ub_target),
        .train_i(train), .train_addr_i(fb_word_i.train.block_addr),
        .train_target_i({fb_word_i.train.target, 1'b0}), .train_taken_i(fb_word_i.train.taken));

    main_btb main_btb_i (.clk, .rst_i, .lookup_addr_i(s2_block_q[31:4]), .hit_o(btb_hit),
        .slot_off_o(btb_off), .type_o(btb_type), .target_o(btb_target), .ctr_o(btb_ctr),
        .train_i(train), .train_word_i(fb_word_i));

    ras_stack ras_stack_i (.clk, .rst_i, .push_i(ras_push), .push_addr_i(ras_push_addr),
        .pop_i(ras_pop), .top_o(ras_top));

    s2_resolve s2_resolve_i (.valid_i(s2_valid_q), .stall_i(stall), .block_i(s2_block_q),
        .s1_target_i(s2_s1_target_q), .btb_hit_i(btb_hit), .slot_off_i(btb_off),
        .type_i(btb_type), .target_i(btb_target), .ctr_i(btb_ctr), .ras_top_i(ras_top),
        .push_o(ras_push), .push_addr_o(ras_push_addr), .pop_o(ras_pop),
        .entry_o(enq_entry_o), .override_o(override));

    // the stack only moves when the stage-2 block is actually handed on.
    a_ras_no_stall: assert property (@(posedge clk) disable iff (rst_i)
        (ras_push || ras_pop) |-> space_i);

    // a held stage-2 block is not written and survives to the next cycle.
    a_s2_hold: assert property (@(posedge clk) disable iff (rst_i)
        (s2_valid_q && !space_i && !squash) |-> !enq_o ##1 (s2_valid_q && $stable(s2_block_q)));

endmodule

`default_nettype wire

// File: design/ras_stack.sv
`timescale 1ns/100ps
`default_nettype none
`include "bpu_consts.svh"

module ras_stack #(
    parameter int DEPTH = `BPU_RAS_DEPTH
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        push_i,
    input  logic [31:0] push_addr_i,
    input  logic        pop_i,
    output logic [31:0] top_o
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [31:0]      stack_q [DEPTH];
    logic [PTR_W-1:0] ptr_q;                    // points at the top.
    logic [PTR_W-1:0] ptr_inc;
    logic [PTR_W-1:0] ptr_dec;

    // circular, so overflow just overwrites the oldest return.
    assign ptr_inc = (ptr_q == PTR_W'(DEPTH - 1)) ? '0 : ptr_q + 1'b1;
    assign ptr_dec = (ptr_q == '0) ? PTR_W'(DEPTH - 1) : ptr_q - 1'b1;
    assign top_o   = stack_q[ptr_q];

    always_ff @(posedge clk) begin
        if (rst_i) ptr_q <= '0;
        else if (push_i && !pop_i) ptr_q <= ptr_inc;
        else if (pop_i && !push_i) ptr_q <= ptr_dec;    // empty pop just wraps.
    end

    always_ff @(posedge clk) begin
        if (push_i && pop_i) stack_q[ptr_q] <= push_addr_i;   // replace top.
        else if (push_i) stack_q[ptr_inc] <= push_addr_i;
    end

endmodule

`default_nettype wire

// File: design/s2_resolve.sv
`timescale 1ns/100ps
`default_nettype none

module s2_resolve (
    input  logic                   valid_i,
    input  logic                   stall_i,
    input  logic [31:0]            block_i,
    input  logic [31:0]            s1_target_i,
    input  logic                   btb_hit_i,
    input  logic [1:0]             slot_off_i,
    input  bpu_pkg::br_type_e      type_i,
    input  logic [31:0]            target_i,
    input  logic [1:0]             ctr_i,
    input  logic [31:0]            ras_top_i,
    output logic                   push_o,
    output logic [31:0]            push_addr_o,
    output logic                   pop_o,
    output bpu_pkg::stream_entry_t entry_o,
    output logic                   override_o
);
    import bpu_pkg::*;

    logic        taken;
    logic        fire;
    logic [31:0] next_pc;
    logic [2:0]  ret_slots;

    // conditionals follow the counter, everything else is always taken.
    assign taken = btb_hit_i && ((type_i != BR_COND) || ctr_i[1]);
    assign fire  = valid_i && !stall_i;

    always_comb begin
        if (!taken)               next_pc = block_i + 32'd16;
        else if (type_i == BR_RET) next_pc = ras_top_i;
        else                      next_pc = target_i;
    end

    assign entry_o.start   = block_i;
    assign entry_o.end_off = taken ? slot_off_i : 2'd3;
    assign entry_o.taken   = taken;
    assign entry_o.target  = next_pc;

    // return address is the instruction after the call.
    assign ret_slots   = {1'b0, slot_off_i} + 3'd1;
    assign push_addr_o = block_i + {27'd0, ret_slots, 2'b00};
    assign push_o      = fire && taken && (type_i == BR_CALL);
    assign pop_o       = fire && taken && (type_i == BR_RET);

    assign override_o = valid_i && (next_pc != s1_target_i);

endmodule

`default_nettype wire

// File: design/stream_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "bpu_consts.svh"

module stream_queue #(
    parameter int DEPTH = `BPU_QUEUE_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   enq_i,
    input  bpu_pkg::stream_entry_t enq_entry_i,
    input  logic                   flush_i,
    output logic                   space_o,
    input  logic                   deq_i,
    output logic                   valid_o,
    output bpu_pkg::stream_entry_t head_o
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    stream_entry_t    mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_enq, do_deq;

    assign valid_o = (count_q != '0);
    assign head_o  = mem_q[rd_ptr_q];
    assign space_o = (count_q <= CNT_W'(DEPTH - 2));   // one write may still be in flight.
    assign do_enq  = enq_i && !flush_i;
    assign do_deq  = deq_i && valid_o && !flush_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (do_deq) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + CNT_W'(do_enq) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) mem_q[wr_ptr_q] <= enq_entry_i;
    end

    // the front end must stop writing before the queue fills.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        (do_enq && !do_deq) |-> (count_q < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// File: design/ubtb.sv
`timescale 1ns/100ps
`default_nettype none
`include "bpu_consts.svh"

module ubtb #(
    parameter int ENTRIES = `BPU_UBTB_ENTRIES
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic [31:0] lookup_pc_i,
    output logic        hit_o,
    output logic [31:0] target_o,
    input  logic        train_i,
    input  logic [27:0] train_addr_i,
    input  logic [31:0] train_target_i,
    input  logic        train_taken_i
);
    localparam int IDX_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid_q;
    logic [27:0]        tag_q    [ENTRIES];
    logic [31:0]        target_q [ENTRIES];
    logic [IDX_W-1:0]   rr_q;                   // next victim.
    logic [ENTRIES-1:0] match;
    logic [ENTRIES-1:0] train_match;

    always_comb begin
        target_o = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            match[i]       = valid_q[i] && (tag_q[i] == lookup_pc_i[31:4]);
            train_match[i] = valid_q[i] && (tag_q[i] == train_addr_i);
            if (match[i]) target_o = target_q[i];
        end
    end
    assign hit_o = |match;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (train_i && train_taken_i && !(|train_match)) begin
            valid_q[rr_q] <= 1'b1;
            rr_q <= (rr_q == IDX_W'(ENTRIES - 1)) ? '0 : rr_q + 1'b1;
        end else if (train_i && !train_taken_i) begin
            valid_q <= valid_q & ~train_match;  // not taken, drop it.
        end
    end

    always_ff @(posedge clk) begin
        if (train_i && train_taken_i) begin
            if (|train_match) begin
                for (int i = 0; i < ENTRIES; i++)
                    if (train_match[i]) target_q[i] <= train_target_i;
            end else begin
                tag_q[rr_q]    <= train_addr_i;
                target_q[rr_q] <= train_target_i;
            end
        end
    end

    // allocation only happens on a miss, so tags stay unique.
    a_one_match: assert property (@(posedge clk) disable iff (rst_i) $onehot0(match));

endmodule

`default_nettype wire
